// ==== list.f ====
src/io_map_pkg.sv
src/periph_cfg_pkg.sv
src/io_addr_decode.sv
src/parallel_port.sv
src/timer_counter0.sv
src/watchdog.sv
src/io_read_merge.sv
src/peripherals.sv
testbench/tb_clock_gen.sv
testbench/tb_peripherals.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the I/O peripheral testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_peripherals -Mdir "$build_dir" -f list.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/Vtb_peripherals" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "ERRORS FOUND" "$log_file"; then
   echo "Simulation reported a failure"
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

echo "Simulation passed"
exit 0

// ==== src/io_addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_addr_decode (
   input  wire                 cp2,
   input  wire                 reset,
   input  wire io_map_pkg::io_adr_t adr,
   input  wire                 iore,
   input  wire                 iowe,
   output logic                rd_pina,
   output logic                wr_ddra,
   output logic                wr_porta,
   output logic                rd_ddra,
   output logic                rd_porta,
   output logic                wr_wdtcr,
   output logic                rd_wdtcr,
   output logic                wr_tccr0,
   output logic                rd_tccr0,
   output logic                wr_tcnt0,
   output logic                rd_tcnt0,
   output logic                wr_ocr0,
   output logic                rd_ocr0
);

   import io_map_pkg::*;

   // Address match, shared by both strobes
   logic hit_pina;
   logic hit_ddra;
   logic hit_porta;
   logic hit_wdtcr;
   logic hit_tccr0;
   logic hit_tcnt0;
   logic hit_ocr0;

   assign hit_pina  = (adr == PINA_ADR);
   assign hit_ddra  = (adr == DDRA_ADR);
   assign hit_porta = (adr == PORTA_ADR);
   assign hit_wdtcr = (adr == WDTCR_ADR);
   assign hit_tccr0 = (adr == TCCR0_ADR);
   assign hit_tcnt0 = (adr == TCNT0_ADR);
   assign hit_ocr0  = (adr == OCR0_ADR);

   // PINA is read only
   assign rd_pina  = iore & hit_pina;
   assign rd_ddra  = iore & hit_ddra;
   assign wr_ddra  = iowe & hit_ddra;
   assign rd_porta = iore & hit_porta;
   assign wr_porta = iowe & hit_porta;
   assign rd_wdtcr = iore & hit_wdtcr;
   assign wr_wdtcr = iowe & hit_wdtcr;
   assign rd_tccr0 = iore & hit_tccr0;
   assign wr_tccr0 = iowe & hit_tccr0;
   assign rd_tcnt0 = iore & hit_tcnt0;
   assign wr_tcnt0 = iowe & hit_tcnt0;
   assign rd_ocr0  = iore & hit_ocr0;
   assign wr_ocr0  = iowe & hit_ocr0;

   // Never two registers in one access
   a_one_sel: assert property (@(posedge cp2) disable iff (reset)
      $onehot0({rd_pina, rd_ddra, rd_porta, rd_wdtcr, rd_tccr0, rd_tcnt0, rd_ocr0}) &&
      $onehot0({wr_ddra, wr_porta, wr_wdtcr, wr_tccr0, wr_tcnt0, wr_ocr0}));

endmodule

`default_nettype wire

// ==== src/io_map_pkg.sv ====
`default_nettype none

package io_map_pkg;

   // Bus word types
   typedef logic [5:0] io_adr_t;
   typedef logic [7:0] io_data_t;

   // ===================================================================
   // I/O register map
   // ===================================================================

   // Parallel port A
   localparam io_adr_t PINA_ADR  = 6'h19;
   localparam io_adr_t DDRA_ADR  = 6'h1A;
   localparam io_adr_t PORTA_ADR = 6'h1B;

   // Watchdog control
   localparam io_adr_t WDTCR_ADR = 6'h21;

   // Timer/counter 0
   localparam io_adr_t TCNT0_ADR = 6'h32;
   localparam io_adr_t TCCR0_ADR = 6'h33;
   localparam io_adr_t OCR0_ADR  = 6'h3C;

   // Slots on the read merge chain
   localparam int IO_SLV_NUM = 3;

endpackage

`default_nettype wire

// ==== src/io_read_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_read_merge (
   input  wire                             cp2,
   input  wire                             reset,
   input  wire io_map_pkg::io_data_t       slv_data [io_map_pkg::IO_SLV_NUM],
   input  wire [io_map_pkg::IO_SLV_NUM-1:0] slv_en,
   output io_map_pkg::io_data_t            dbus_out,
   output logic                            out_en
);

   import io_map_pkg::*;

   // Stage i holds the merged result of slots below i
   io_data_t            chain_data [IO_SLV_NUM+1];
   logic [IO_SLV_NUM:0] chain_en;

   assign chain_data[0] = '0;
   assign chain_en[0]   = 1'b0;

   // Higher slot overrides whatever came up the chain
   for (genvar i = 0; i < IO_SLV_NUM; i++) begin : g_chain
      assign chain_en[i+1]   = slv_en[i] | chain_en[i];
      assign chain_data[i+1] = slv_en[i] ? slv_data[i] : chain_data[i];
   end

   assign out_en   = chain_en[IO_SLV_NUM];
   assign dbus_out = chain_data[IO_SLV_NUM];

   // Decode guarantees a single driver per read
   a_one_slv: assert property (@(posedge cp2) disable iff (reset)
      $onehot0(slv_en));

endmodule

`default_nettype wire

// ==== src/parallel_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module parallel_port #(
   parameter int port_width = 8
) (
   input  wire                       cp2,
   input  wire                       reset,
   input  wire                       wr_ddra,
   input  wire                       wr_porta,
   input  wire                       rd_ddra,
   input  wire                       rd_porta,
   input  wire                       rd_pina,
   input  wire io_map_pkg::io_data_t dbus_in,
   input  wire [port_width-1:0]      porta_pinx,
   output logic [port_width-1:0]     porta_portx,
   output logic [port_width-1:0]     porta_ddrx,
   output io_map_pkg::io_data_t      rd_data,
   output logic                      rd_en
);

   import io_map_pkg::*;

   // Two stage pin synchronizer
   logic [port_width-1:0] pin_meta;
   logic [port_width-1:0] pin_sync;

   // ===================================================================
   // Data and direction registers
   // ===================================================================
   always_ff @(posedge cp2) begin
      if (reset) begin
         porta_portx <= '0;
         porta_ddrx  <= '0;
      end else begin
         if (wr_porta) begin
            porta_portx <= dbus_in[port_width-1:0];
         end
         if (wr_ddra) begin
            porta_ddrx <= dbus_in[port_width-1:0];
         end
      end
   end

   always_ff @(posedge cp2) begin
      if (reset) begin
         pin_meta <= '0;
         pin_sync <= '0;
      end else begin
         pin_meta <= porta_pinx;
         pin_sync <= pin_meta;
      end
   end

   // Read back, zero when not addressed
   always_comb begin
      rd_data = '0;
      if (rd_pina) begin
         rd_data = io_data_t'(pin_sync);
      end else if (rd_ddra) begin
         rd_data = io_data_t'(porta_ddrx);
      end else if (rd_porta) begin
         rd_data = io_data_t'(porta_portx);
      end
   end

   assign rd_en = rd_pina | rd_ddra | rd_porta;

endmodule

`default_nettype wire

// ==== src/periph_cfg_pkg.sv ====
`default_nettype none

package periph_cfg_pkg;

   // Interrupt vector width and the timer 0 line positions
   localparam int IRQS_WIDTH  = 23;
   localparam int IRQ_TC0_OVF = 15;
   localparam int IRQ_TC0_CMP = 14;

   // ===================================================================
   // Timer 0 clock select, TCCR0[1:0]
   // ===================================================================
   localparam logic [1:0] TC_CS_STOP = 2'd0;
   localparam logic [1:0] TC_CS_CLK  = 2'd1;
   localparam logic [1:0] TC_CS_EXT1 = 2'd2;
   localparam logic [1:0] TC_CS_EXT2 = 2'd3;

   // ===================================================================
   // Watchdog
   // ===================================================================

   // Timeout is 2**(base + prescale) cycles
   localparam int WDT_TIMEOUT_BASE = 8;

endpackage

`default_nettype wire

// ==== src/peripherals.sv ====
`timescale 1ns/1ps
`default_nettype none

module peripherals #(
   parameter int port_width    = 8,
   parameter int wdt_cnt_width = 16
) (
   input  wire                                   cp2,
   input  wire                                   reset,
   input  wire io_map_pkg::io_adr_t              adr,
   input  wire                                   iore,
   input  wire                                   iowe,
   input  wire io_map_pkg::io_data_t             dbus_in,
   output io_map_pkg::io_data_t                  dbus_out,
   output logic                                  out_en,
   output logic [periph_cfg_pkg::IRQS_WIDTH-1:0] irqlines,
   input  wire  [periph_cfg_pkg::IRQS_WIDTH-1:0] irq_ack,
   output logic [port_width-1:0]                 porta_portx,
   output logic [port_width-1:0]                 porta_ddrx,
   input  wire  [port_width-1:0]                 porta_pinx,
   input  wire                                   tmr_ext_1,
   input  wire                                   tmr_ext_2,
   input  wire                                   wdri,
   output logic                                  wdt_wdovf
);

   import io_map_pkg::*;
   import periph_cfg_pkg::*;

   // Register selects
   logic rd_pina;
   logic wr_ddra;
   logic wr_porta;
   logic rd_ddra;
   logic rd_porta;
   logic wr_wdtcr;
   logic rd_wdtcr;
   logic wr_tccr0;
   logic rd_tccr0;
   logic wr_tcnt0;
   logic rd_tcnt0;
   logic wr_ocr0;
   logic rd_ocr0;

   // Read slots: 0 port, 1 timer, 2 watchdog
   wire io_data_t        slv_data [IO_SLV_NUM];
   wire [IO_SLV_NUM-1:0] slv_en;

   logic tc0_ovf_irq;
   logic tc0_cmp_irq;

   // ===================================================================
   // Decode
   // ===================================================================
   io_addr_decode io_addr_decode_inst (
      .cp2      (cp2),
      .reset    (reset),
      .adr      (adr),
      .iore     (iore),
      .iowe     (iowe),
      .rd_pina  (rd_pina),
      .wr_ddra  (wr_ddra),
      .wr_porta (wr_porta),
      .rd_ddra  (rd_ddra),
      .rd_porta (rd_porta),
      .wr_wdtcr (wr_wdtcr),
      .rd_wdtcr (rd_wdtcr),
      .wr_tccr0 (wr_tccr0),
      .rd_tccr0 (rd_tccr0),
      .wr_tcnt0 (wr_tcnt0),
      .rd_tcnt0 (rd_tcnt0),
      .wr_ocr0  (wr_ocr0),
      .rd_ocr0  (rd_ocr0)
   );

   // ===================================================================
   // Peripherals
   // ===================================================================
   parallel_port #(
      .port_width (port_width)
   ) parallel_port_inst (
      .cp2         (cp2),
      .reset       (reset),
      .wr_ddra     (wr_ddra),
      .wr_porta    (wr_porta),
      .rd_ddra     (rd_ddra),
      .rd_porta    (rd_porta),
      .rd_pina     (rd_pina),
      .dbus_in     (dbus_in),
      .porta_pinx  (porta_pinx),
      .porta_portx (porta_portx),
      .porta_ddrx  (porta_ddrx),
      .rd_data     (slv_data[0]),
      .rd_en       (slv_en[0])
   );

   timer_counter0 timer_counter0_inst (
      .cp2       (cp2),
      .reset     (reset),
      .wr_tccr0  (wr_tccr0),
      .rd_tccr0  (rd_tccr0),
      .wr_tcnt0  (wr_tcnt0),
      .rd_tcnt0  (rd_tcnt0),
      .wr_ocr0   (wr_ocr0),
      .rd_ocr0   (rd_ocr0),
      .dbus_in   (dbus_in),
      .tmr_ext_1 (tmr_ext_1),
      .tmr_ext_2 (tmr_ext_2),
      .ovf_ack   (irq_ack[IRQ_TC0_OVF]),
      .cmp_ack   (irq_ack[IRQ_TC0_CMP]),
      .ovf_irq   (tc0_ovf_irq),
      .cmp_irq   (tc0_cmp_irq),
      .rd_data   (slv_data[1]),
      .rd_en     (slv_en[1])
   );

   watchdog #(
      .wdt_cnt_width (wdt_cnt_width)
   ) watchdog_inst (
      .cp2       (cp2),
      .reset     (reset),
      .wr_wdtcr  (wr_wdtcr),
      .rd_wdtcr  (rd_wdtcr),
      .wdri      (wdri),
      .dbus_in   (dbus_in),
      .wdt_wdovf (wdt_wdovf),
      .rd_data   (slv_data[2]),
      .rd_en     (slv_en[2])
   );

   // ===================================================================
   // Read merge and interrupt vector
   // ===================================================================
   io_read_merge io_read_merge_inst (
      .cp2      (cp2),
      .reset    (reset),
      .slv_data (slv_data),
      .slv_en   (slv_en),
      .dbus_out (dbus_out),
      .out_en   (out_en)
   );

   // Only the timer 0 lines are live
   always_comb begin
      irqlines              = '0;
      irqlines[IRQ_TC0_OVF] = tc0_ovf_irq;
      irqlines[IRQ_TC0_CMP] = tc0_cmp_irq;
   end

endmodule

`default_nettype wire

// ==== src/timer_counter0.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_counter0 (
   input  wire                       cp2,
   input  wire                       reset,
   input  wire                       wr_tccr0,
   input  wire                       rd_tccr0,
   input  wire                       wr_tcnt0,
   input  wire                       rd_tcnt0,
   input  wire                       wr_ocr0,
   input  wire                       rd_ocr0,
   input  wire io_map_pkg::io_data_t dbus_in,
   input  wire                       tmr_ext_1,
   input  wire                       tmr_ext_2,
   input  wire                       ovf_ack,
   input  wire                       cmp_ack,
   output logic                      ovf_irq,
   output logic                      cmp_irq,
   output io_map_pkg::io_data_t      rd_data,
   output logic                      rd_en
);

   import periph_cfg_pkg::*;

   logic [1:0] tccr0_cs;
   logic [7:0] tcnt0;
   logic [7:0] ocr0;
   logic [7:0] tcnt0_next;

   // External inputs, bit 0 is ext_1 and bit 1 is ext_2
   logic [1:0] ext_meta;
   logic [1:0] ext_sync;
   logic [1:0] ext_prev;
   logic [1:0] ext_edge;

   logic cnt_inc;
   logic ovf_set;
   logic cmp_set;

   // ===================================================================
   // External clock sync and rising edge detect
   // ===================================================================
   always_ff @(posedge cp2) begin
      if (reset) begin
         ext_meta <= '0;
         ext_sync <= '0;
         ext_prev <= '0;
         ext_edge <= '0;
      end else begin
         ext_meta <= {tmr_ext_2, tmr_ext_1};
         ext_sync <= ext_meta;
         ext_prev <= ext_sync;
         ext_edge <= ext_sync & ~ext_prev;
      end
   end

   // Count source
   always_comb begin
      case (tccr0_cs)
         TC_CS_STOP: cnt_inc = 1'b0;
         TC_CS_CLK:  cnt_inc = 1'b1;
         TC_CS_EXT1: cnt_inc = ext_edge[0];
         TC_CS_EXT2: cnt_inc = ext_edge[1];
      endcase
   end

   assign tcnt0_next = tcnt0 + 8'd1;

   // A TCNT0 write suppresses both the increment and its flags
   assign ovf_set = cnt_inc & ~wr_tcnt0 & (tcnt0 == 8'hFF);
   assign cmp_set = cnt_inc & ~wr_tcnt0 & (tcnt0_next == ocr0);

   always_ff @(posedge cp2) begin
      if (reset) begin
         tccr0_cs <= TC_CS_STOP;
         tcnt0    <= '0;
         ocr0     <= '0;
         ovf_irq  <= 1'b0;
         cmp_irq  <= 1'b0;
      end else begin
         if (wr_tccr0) begin
            tccr0_cs <= dbus_in[1:0];
         end
         if (wr_ocr0) begin
            ocr0 <= dbus_in;
         end
         if (wr_tcnt0) begin
            tcnt0 <= dbus_in;
         end else if (cnt_inc) begin
            tcnt0 <= tcnt0_next;
         end
         // Set wins over ack
         if (ovf_set) begin
            ovf_irq <= 1'b1;
         end else if (ovf_ack) begin
            ovf_irq <= 1'b0;
         end
         if (cmp_set) begin
            cmp_irq <= 1'b1;
         end else if (cmp_ack) begin
            cmp_irq <= 1'b0;
         end
      end
   end

   always_comb begin
      rd_data = '0;
      if (rd_tccr0) begin
         rd_data = {6'b0, tccr0_cs};
      end else if (rd_tcnt0) begin
         rd_data = tcnt0;
      end else if (rd_ocr0) begin
         rd_data = ocr0;
      end
   end

   assign rd_en = rd_tccr0 | rd_tcnt0 | rd_ocr0;

   a_ovf_ack: assert property (@(posedge cp2) disable iff (reset)
      ovf_ack && !ovf_set |=> !ovf_irq);
   a_cmp_ack: assert property (@(posedge cp2) disable iff (reset)
      cmp_ack && !cmp_set |=> !cmp_irq);

endmodule

`default_nettype wire

// ==== src/watchdog.sv ====
`timescale 1ns/1ps
`default_nettype none

module watchdog #(
   parameter int wdt_cnt_width = 16
) (
   input  wire                       cp2,
   input  wire                       reset,
   input  wire                       wr_wdtcr,
   input  wire                       rd_wdtcr,
   input  wire                       wdri,
   input  wire io_map_pkg::io_data_t dbus_in,
   output logic                      wdt_wdovf,
   output io_map_pkg::io_data_t      rd_data,
   output logic                      rd_en
);

   import periph_cfg_pkg::*;

   localparam logic [wdt_cnt_width-1:0] cnt_one = 1;

   // WDTCR fields
   logic       wde;
   logic [2:0] wdp;

   logic [wdt_cnt_width-1:0] wdt_cnt;
   logic [wdt_cnt_width-1:0] wdt_limit;
   logic                     wdt_clr;
   logic                     wdt_hit;

   // Last count before the timeout wraps
   assign wdt_limit = (cnt_one << (WDT_TIMEOUT_BASE + int'(wdp))) - cnt_one;

   // Refresh or any control write restarts the count
   assign wdt_clr = wr_wdtcr | wdri;
   assign wdt_hit = wde & (wdt_cnt == wdt_limit);

   // ===================================================================
   // Control register, counter and overflow pulse
   // ===================================================================
   always_ff @(posedge cp2) begin
      if (reset) begin
         wde       <= 1'b0;
         wdp       <= '0;
         wdt_cnt   <= '0;
         wdt_wdovf <= 1'b0;
      end else begin
         if (wr_wdtcr) begin
            wde <= dbus_in[3];
            wdp <= dbus_in[2:0];
         end
         if (wdt_clr || wdt_hit) begin
            wdt_cnt <= '0;
         end else if (wde) begin
            wdt_cnt <= wdt_cnt + cnt_one;
         end
         wdt_wdovf <= wdt_hit & ~wdt_clr;
      end
   end

   // Upper nibble reads as zero
   assign rd_data = rd_wdtcr ? {4'b0, wde, wdp} : '0;
   assign rd_en   = rd_wdtcr;

   a_ovf_pulse: assert property (@(posedge cp2) disable iff (reset)
      wdt_wdovf |=> !wdt_wdovf);

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int period_ns    = 4,
   parameter int reset_cycles = 4
) (
   output logic cp2,
   output logic reset
);

   initial begin
      cp2 = 1'b0;
      forever #(period_ns / 2.0) cp2 = ~cp2;
   end

   // Synchronous reset, released on a rising edge
   initial begin
      reset <= 1'b1;
      repeat (reset_cycles) @(posedge cp2);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_peripherals.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_peripherals;

   import io_map_pkg::*;
   import periph_cfg_pkg::*;

   localparam int max_cycles = 20000;
   localparam logic [IRQS_WIDTH-1:0] live_irqs =
      (IRQS_WIDTH'(1) << IRQ_TC0_OVF) | (IRQS_WIDTH'(1) << IRQ_TC0_CMP);

   logic                  cp2;
   logic                  reset;
   io_adr_t               adr;
   logic                  iore;
   logic                  iowe;
   io_data_t              dbus_in;
   io_data_t              dbus_out;
   logic                  out_en;
   logic [IRQS_WIDTH-1:0] irqlines;
   logic [IRQS_WIDTH-1:0] irq_ack;
   logic [7:0]            porta_portx;
   logic [7:0]            porta_ddrx;
   logic [7:0]            porta_pinx;
   logic                  tmr_ext_1;
   logic                  tmr_ext_2;
   logic                  wdri;
   logic                  wdt_wdovf;

   // Register model
   io_data_t m_pina;
   io_data_t m_ddra;
   io_data_t m_porta;
   io_data_t m_wdtcr;
   io_data_t m_tccr0;
   io_data_t m_tcnt0;
   io_data_t m_ocr0;

   // Pending read check, seen by the compare process
   logic        chk_req;
   logic        exp_en;
   io_data_t    exp_data;
   logic [31:0] rng_state;
   int          cyc = 0;

   tb_clock_gen #(
      .period_ns    (4),
      .reset_cycles (4)
   ) tb_clock_gen_inst (
      .cp2   (cp2),
      .reset (reset)
   );

   peripherals #(
      .port_width    (8),
      .wdt_cnt_width (16)
   ) peripherals_inst (
      .cp2         (cp2),
      .reset       (reset),
      .adr         (adr),
      .iore        (iore),
      .iowe        (iowe),
      .dbus_in     (dbus_in),
      .dbus_out    (dbus_out),
      .out_en      (out_en),
      .irqlines    (irqlines),
      .irq_ack     (irq_ack),
      .porta_portx (porta_portx),
      .porta_ddrx  (porta_ddrx),
      .porta_pinx  (porta_pinx),
      .tmr_ext_1   (tmr_ext_1),
      .tmr_ext_2   (tmr_ext_2),
      .wdri        (wdri),
      .wdt_wdovf   (wdt_wdovf)
   );

   // ===================================================================
   // Reference model, random source and checking
   // ===================================================================
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Expected {out_en, dbus_out} for a read at a
   function automatic logic [8:0] ref_read(input io_adr_t a);
      case (a)
         PINA_ADR:  return {1'b1, m_pina};
         DDRA_ADR:  return {1'b1, m_ddra};
         PORTA_ADR: return {1'b1, m_porta};
         WDTCR_ADR: return {1'b1, m_wdtcr};
         TCCR0_ADR: return {1'b1, m_tccr0};
         TCNT0_ADR: return {1'b1, m_tcnt0};
         OCR0_ADR:  return {1'b1, m_ocr0};
         default:   return 9'h000;
      endcase
   endfunction

   task automatic next_rand(output logic [31:0] r);
      rng_state = lcg_next(rng_state);
      r = rng_state;
   endtask

   task automatic stop_on_failure(input string msg);
      $display("Failure at time %0t: %s", $time, msg);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
   endtask

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] time %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "simulation stopped");
      end
   endtask

   always @(negedge cp2) begin
      if (!reset) begin
         if (chk_req) begin
            compare_value($sformatf("dbus_out at adr 0x%0h", adr), 32'(dbus_out),
                          32'(exp_data));
            compare_value("out_en", 32'(out_en), 32'(exp_en));
         end
         compare_value("unused irqlines", 32'(irqlines & ~live_irqs), 32'd0);
      end
   end

   always @(posedge cp2) begin
      cyc <= cyc + 1;
      if (cyc >= max_cycles) begin
         $display("Timeout: the run went past %0d cycles", max_cycles);
         $display("ERRORS FOUND");
         $fatal(1, "timeout");
      end
   end

   // ===================================================================
   // Bus operations, one cycle each
   // ===================================================================
   task automatic bus_idle(input int n);
      repeat (n) begin
         @(posedge cp2);
         iore    <= 1'b0;
         iowe    <= 1'b0;
         chk_req <= 1'b0;
      end
   endtask

   task automatic io_write(input io_adr_t a, input io_data_t d);
      @(posedge cp2);
      adr     <= a;
      dbus_in <= d;
      iowe    <= 1'b1;
      iore    <= 1'b0;
      chk_req <= 1'b0;
      // Model takes the value the register holds after this edge
      case (a)
         DDRA_ADR:  m_ddra  = d;
         PORTA_ADR: m_porta = d;
         WDTCR_ADR: m_wdtcr = {4'h0, d[3:0]};
         TCCR0_ADR: m_tccr0 = {6'h0, d[1:0]};
         TCNT0_ADR: m_tcnt0 = d;
         OCR0_ADR:  m_ocr0  = d;
         default:   ;
      endcase
   endtask

   task automatic io_read(input io_adr_t a);
      @(posedge cp2);
      adr                <= a;
      iore               <= 1'b1;
      iowe               <= 1'b0;
      {exp_en, exp_data} <= ref_read(a);
      chk_req            <= 1'b1;
   endtask

   task automatic set_pins(input logic [7:0] v);
      @(posedge cp2);
      iore       <= 1'b0;
      iowe       <= 1'b0;
      chk_req    <= 1'b0;
      porta_pinx <= v;
      m_pina = v;
   endtask

   task automatic ack_irq(input int idx);
      @(posedge cp2);
      iore         <= 1'b0;
      iowe         <= 1'b0;
      chk_req      <= 1'b0;
      irq_ack[idx] <= 1'b1;
      @(posedge cp2);
      irq_ack <= '0;
   endtask

   task automatic wait_irq(input int idx);
      int n;
      n = 0;
      do begin
         bus_idle(1);
         @(negedge cp2);
         n++;
         if (n > 64) begin
            stop_on_failure($sformatf("IRQ line %0d never rose", idx));
         end
      end while (!irqlines[idx]);
   endtask

   // Selected input rises once per period and the other one twice
   task automatic ext_burst(input int k, input logic on_ext1);
      logic a;
      logic b;
      for (int i = 0; i < k; i++) begin
         for (int c = 0; c < 8; c++) begin
            a = (c < 4);
            b = (c == 2) || (c == 5);
            bus_idle(1);
            tmr_ext_1 <= on_ext1 ? a : b;
            tmr_ext_2 <= on_ext1 ? b : a;
         end
      end
   endtask

   task automatic watch_wdovf(input int n_cycles, input int wdri_period, output int pulses);
      int   gap;
      logic prev;
      pulses = 0;
      gap    = 0;
      prev   = 1'b0;
      for (int i = 0; i < n_cycles; i++) begin
         bus_idle(1);
         wdri <= (wdri_period > 0) && (i % wdri_period == 0);
         @(negedge cp2);
         gap++;
         if (wdt_wdovf) begin
            if (prev) begin
               stop_on_failure("wdt_wdovf stayed high for two cycles in a row");
            end
            if (pulses == 0) begin
               compare_value("first wdovf within timeout", 32'(gap <= 257), 32'd1);
            end else begin
               compare_value("wdovf spacing", 32'(gap), 32'd256);
            end
            pulses++;
            gap = 0;
         end
         prev = wdt_wdovf;
      end
   endtask

   // ===================================================================
   // Test sequences
   // ===================================================================
   task automatic port_registers();
      logic [31:0] r;
      for (int i = 0; i < 8; i++) begin
         next_rand(r);
         io_write(DDRA_ADR, r[31:24]);
         io_write(PORTA_ADR, r[23:16]);
         io_read(DDRA_ADR);
         io_read(PORTA_ADR);
         @(negedge cp2);
         compare_value("porta_ddrx", 32'(porta_ddrx), 32'(m_ddra));
         compare_value("porta_portx", 32'(porta_portx), 32'(m_porta));
         // Two sync flops before PINA
         set_pins(r[15:8]);
         bus_idle(2);
         io_read(PINA_ADR);
      end
      io_read(6'h00);
      io_read(6'h3F);
      bus_idle(1);
   endtask

   task automatic clk_counting();
      logic [31:0] r;
      io_data_t    v;
      int          n;
      for (int i = 0; i < 4; i++) begin
         next_rand(r);
         v = r[31:24];
         n = 1 + int'(r[5:0]);
         io_write(TCNT0_ADR, v);
         io_write(TCCR0_ADR, {6'h0, TC_CS_CLK});
         io_read(TCCR0_ADR);
         bus_idle(n - 1);
         m_tcnt0 = v + 8'(n);
         io_read(TCNT0_ADR);
         // One more increment lands with the STOP write
         io_write(TCCR0_ADR, {6'h0, TC_CS_STOP});
         m_tcnt0 = v + 8'(n + 2);
         io_read(TCCR0_ADR);
         bus_idle(3);
         io_read(TCNT0_ADR);
      end
      bus_idle(1);
   endtask

   task automatic irq_sequence();
      io_write(TCCR0_ADR, {6'h0, TC_CS_STOP});
      io_write(OCR0_ADR, 8'd252);
      io_write(TCNT0_ADR, 8'd250);
      ack_irq(IRQ_TC0_CMP);
      ack_irq(IRQ_TC0_OVF);
      @(negedge cp2);
      compare_value("cmp irq after clear", 32'(irqlines[IRQ_TC0_CMP]), 32'd0);
      compare_value("ovf irq after clear", 32'(irqlines[IRQ_TC0_OVF]), 32'd0);
      io_write(TCCR0_ADR, {6'h0, TC_CS_CLK});
      wait_irq(IRQ_TC0_CMP);
      compare_value("ovf irq before cmp", 32'(irqlines[IRQ_TC0_OVF]), 32'd0);
      wait_irq(IRQ_TC0_OVF);
      compare_value("cmp irq held", 32'(irqlines[IRQ_TC0_CMP]), 32'd1);
      io_write(TCCR0_ADR, {6'h0, TC_CS_STOP});
      io_write(TCNT0_ADR, 8'd0);
      bus_idle(4);
      @(negedge cp2);
      compare_value("cmp irq held", 32'(irqlines[IRQ_TC0_CMP]), 32'd1);
      compare_value("ovf irq held", 32'(irqlines[IRQ_TC0_OVF]), 32'd1);
      ack_irq(IRQ_TC0_CMP);
      @(negedge cp2);
      compare_value("cmp irq after ack", 32'(irqlines[IRQ_TC0_CMP]), 32'd0);
      compare_value("ovf irq before ack", 32'(irqlines[IRQ_TC0_OVF]), 32'd1);
      ack_irq(IRQ_TC0_OVF);
      bus_idle(3);
      @(negedge cp2);
      compare_value("cmp irq stays low", 32'(irqlines[IRQ_TC0_CMP]), 32'd0);
      compare_value("ovf irq after ack", 32'(irqlines[IRQ_TC0_OVF]), 32'd0);
   endtask

   task automatic ext_counting();
      logic [31:0] r;
      int          k;
      for (int sel = 0; sel < 2; sel++) begin
         next_rand(r);
         k = 3 + int'(r[2:0]);
         io_write(TCNT0_ADR, r[31:24]);
         io_write(TCCR0_ADR, {6'h0, (sel == 0) ? TC_CS_EXT1 : TC_CS_EXT2});
         ext_burst(k, sel == 0);
         // Let the sync and edge pipeline drain
         bus_idle(6);
         m_tcnt0 = r[31:24] + 8'(k);
         io_read(TCNT0_ADR);
         io_write(TCCR0_ADR, {6'h0, TC_CS_STOP});
      end
      bus_idle(1);
   endtask

   task automatic watchdog_timeout();
      int pulses;
      io_write(WDTCR_ADR, 8'hFF);
      io_read(WDTCR_ADR);
      io_write(WDTCR_ADR, 8'h08);
      watch_wdovf(900, 0, pulses);
      compare_value("wdovf pulses seen", 32'(pulses >= 3), 32'd1);
      io_write(WDTCR_ADR, 8'h08);
      watch_wdovf(600, 100, pulses);
      compare_value("wdovf pulses with refresh", 32'(pulses), 32'd0);
      io_write(WDTCR_ADR, 8'h00);
      watch_wdovf(600, 0, pulses);
      compare_value("wdovf pulses while disabled", 32'(pulses), 32'd0);
      io_read(WDTCR_ADR);
      bus_idle(1);
   endtask

   task automatic random_traffic();
      io_adr_t     wr_adrs [4] = '{DDRA_ADR, PORTA_ADR, OCR0_ADR, WDTCR_ADR};
      io_adr_t     rd_adrs [8] = '{PINA_ADR, DDRA_ADR, PORTA_ADR, WDTCR_ADR,
                                   TCNT0_ADR, TCCR0_ADR, OCR0_ADR, 6'h05};
      logic [31:0] r;
      io_data_t    d;
      for (int i = 0; i < 200; i++) begin
         next_rand(r);
         d = r[23:16];
         // WDE kept clear
         if (wr_adrs[r[1:0]] == WDTCR_ADR) begin
            d = d & ~8'h08;
         end
         io_write(wr_adrs[r[1:0]], d);
         if (r[8]) begin
            io_read(rd_adrs[r[6:4]]);
         end
         io_read(rd_adrs[r[12:10]]);
      end
      bus_idle(1);
      @(negedge cp2);
      compare_value("porta_ddrx", 32'(porta_ddrx), 32'(m_ddra));
      compare_value("porta_portx", 32'(porta_portx), 32'(m_porta));
   endtask

   // ===================================================================
   // Main sequence
   // ===================================================================
   initial begin
      adr        <= '0;
      iore       <= 1'b0;
      iowe       <= 1'b0;
      dbus_in    <= '0;
      irq_ack    <= '0;
      porta_pinx <= '0;
      tmr_ext_1  <= 1'b0;
      tmr_ext_2  <= 1'b0;
      wdri       <= 1'b0;
      chk_req    <= 1'b0;
      exp_en     <= 1'b0;
      exp_data   <= '0;
      m_pina     = '0;
      m_ddra     = '0;
      m_porta    = '0;
      m_wdtcr    = '0;
      m_tccr0    = '0;
      m_tcnt0    = '0;
      m_ocr0     = '0;
      rng_state  = 32'h3090_54f2;

      do @(posedge cp2); while (reset);

      port_registers();
      clk_counting();
      irq_sequence();
      ext_counting();
      watchdog_timeout();
      random_traffic();
      bus_idle(4);

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire
